/* rtl/cpu_isa_pkg.sv */
package cpu_isa_pkg;

   // Basic widths
   localparam int WORD_W = 16;
   localparam int REG_W  = 3;
   localparam int OPC_W  = 5;

   // Data, address and instruction word
   typedef logic [WORD_W-1:0] word_t;
   // Register index
   typedef logic [REG_W-1:0]  reg_idx_t;

   // Register count follows the index width
   localparam int NUM_REGS = 2 ** REG_W;

   // Memory geometry, word addressed
   localparam int MEM_WORDS = 256;
   localparam int MEM_AW    = 8;
   typedef logic [MEM_AW-1:0] mem_idx_t;

   // Byte addressing, so one instruction is two bytes
   localparam word_t PC_STEP = 16'd2;

   // Field positions
   localparam int OPC_LSB = 11;
   localparam int RS_LSB  = 8;
   localparam int RT_LSB  = 5;
   localparam int RD_LSB  = 2;

   // Immediate widths per format
   localparam int IMM5_W  = 5;
   localparam int IMM8_W  = 8;
   localparam int IMM11_W = 11;

   // Opcodes in bits 15:11
   typedef enum logic [OPC_W-1:0] {
      OP_HALT = 5'b00000,
      OP_NOP  = 5'b00001,
      OP_J    = 5'b00100,
      OP_ADDI = 5'b01000,
      OP_BEQZ = 5'b01100,
      OP_BNEZ = 5'b01101,
      OP_ST   = 5'b10000,
      OP_LD   = 5'b10001,
      OP_LBI  = 5'b11000,
      OP_ADD  = 5'b11010,
      OP_SUB  = 5'b11011,
      OP_AND  = 5'b11100,
      OP_XOR  = 5'b11101,
      OP_SLT  = 5'b11110
   } opcode_t;

endpackage

/* rtl/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

   import cpu_isa_pkg::*;

   // ALU functions
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_XOR,
      ALU_SLT,
      ALU_PASSB
   } alu_fn_t;

   // Write-back source
   typedef enum logic {
      WB_ALU,
      WB_MEM
   } wb_sel_t;

   // Control-flow kind
   typedef enum logic [1:0] {
      BR_NONE,
      BR_EQZ,
      BR_NEZ,
      BR_JUMP
   } br_kind_t;

   // Decoded control for one instruction
   typedef struct packed {
      alu_fn_t  alu_fn;
      logic     use_imm;
      logic     rf_we;
      wb_sel_t  wb_sel;
      logic     mem_we;
      br_kind_t br_kind;
      logic     halt;
   } ctrl_t;

   // Record of the retiring instruction
   typedef struct packed {
      logic     valid;
      word_t    pc;
      logic     rf_we;
      reg_idx_t rd;
      word_t    wd;
      logic     mem_we;
      word_t    mem_addr;
      word_t    mem_wd;
   } commit_t;

   // Instruction memory load port
   typedef struct packed {
      logic     we;
      mem_idx_t addr;
      word_t    data;
   } imem_load_t;

endpackage

/* rtl/word_mem.sv */
`timescale 1ns/1ns

module word_mem
   import cpu_isa_pkg::*;
(
   input  logic     clk,
   input  logic     we,
   input  mem_idx_t waddr,
   input  word_t    wdata,
   input  mem_idx_t raddr,
   output word_t    rdata
);

   // Storage array
   word_t mem [MEM_WORDS];

   // Write at the edge
   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // Combinational read
   assign rdata = mem[raddr];

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/1ns

module reg_file
   import cpu_isa_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  reg_idx_t rs,
   input  reg_idx_t rt,
   input  logic     we,
   input  reg_idx_t wsel,
   input  word_t    wdata,
   output word_t    rs_val,
   output word_t    rt_val
);

   word_t regs [NUM_REGS];

   // All registers cleared on reset, R0 included
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[wsel] <= wdata;
      end
   end

   // Reads come from the array
   // Write lands at the edge, next instruction sees it
   assign rs_val = regs[rs];
   assign rt_val = regs[rt];

endmodule

/* rtl/instr_decode.sv */
`timescale 1ns/1ns

module instr_decode
   import cpu_isa_pkg::*;
   import cpu_ctrl_pkg::*;
(
   input  word_t    instr,
   output reg_idx_t rs,
   output reg_idx_t rt,
   output reg_idx_t rd_sel,
   output word_t    imm,
   output ctrl_t    ctrl
);

   opcode_t  op;
   reg_idx_t rd;
   word_t    imm5;
   word_t    imm8;
   word_t    imm11;

   assign op = opcode_t'(instr[OPC_LSB +: OPC_W]);

   // Register fields sit at fixed positions in every format
   assign rs = instr[RS_LSB +: REG_W];
   assign rt = instr[RT_LSB +: REG_W];
   assign rd = instr[RD_LSB +: REG_W];

   // Sign-extended immediates
   assign imm5  = {{(WORD_W-IMM5_W){instr[IMM5_W-1]}}, instr[IMM5_W-1:0]};
   assign imm8  = {{(WORD_W-IMM8_W){instr[IMM8_W-1]}}, instr[IMM8_W-1:0]};
   assign imm11 = {{(WORD_W-IMM11_W){instr[IMM11_W-1]}}, instr[IMM11_W-1:0]};

   always_comb begin
      // NOP defaults, also for unknown opcodes
      ctrl         = '0;
      ctrl.alu_fn  = ALU_ADD;
      ctrl.wb_sel  = WB_ALU;
      ctrl.br_kind = BR_NONE;
      rd_sel       = rd;
      imm          = imm5;
      case (op)
         OP_ADD: ctrl.rf_we = 1'b1;
         OP_SUB: begin
            ctrl.rf_we  = 1'b1;
            ctrl.alu_fn = ALU_SUB;
         end
         OP_AND: begin
            ctrl.rf_we  = 1'b1;
            ctrl.alu_fn = ALU_AND;
         end
         OP_XOR: begin
            ctrl.rf_we  = 1'b1;
            ctrl.alu_fn = ALU_XOR;
         end
         OP_SLT: begin
            ctrl.rf_we  = 1'b1;
            ctrl.alu_fn = ALU_SLT;
         end
         // Immediate forms write Rt
         OP_ADDI, OP_LD: begin
            ctrl.rf_we   = 1'b1;
            ctrl.use_imm = 1'b1;
            rd_sel       = rt;
            if (op == OP_LD) begin
               ctrl.wb_sel = WB_MEM;
            end
         end
         OP_ST: begin
            ctrl.use_imm = 1'b1;
            ctrl.mem_we  = 1'b1;
         end
         // LBI loads the 8-bit immediate into Rs
         OP_LBI: begin
            ctrl.rf_we   = 1'b1;
            ctrl.use_imm = 1'b1;
            ctrl.alu_fn  = ALU_PASSB;
            rd_sel       = rs;
            imm          = imm8;
         end
         OP_BEQZ: begin
            ctrl.br_kind = BR_EQZ;
            imm          = imm8;
         end
         OP_BNEZ: begin
            ctrl.br_kind = BR_NEZ;
            imm          = imm8;
         end
         OP_J: begin
            ctrl.br_kind = BR_JUMP;
            imm          = imm11;
         end
         OP_HALT: ctrl.halt = 1'b1;
         default: ;
      endcase
   end

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ns

module alu
   import cpu_isa_pkg::*;
   import cpu_ctrl_pkg::*;
(
   input  word_t a,
   input  word_t rt_val,
   input  word_t imm,
   input  ctrl_t ctrl,
   output word_t result
);

   word_t b;

   // Operand B from immediate or Rt
   assign b = ctrl.use_imm ? imm : rt_val;

   always_comb begin
      case (ctrl.alu_fn)
         // Also the LD/ST address, Rs + imm
         ALU_ADD: result = a + b;
         ALU_SUB: result = a - b;
         ALU_AND: result = a & b;
         ALU_XOR: result = a ^ b;
         // Signed compare, result is 0 or 1
         ALU_SLT: begin
            if ($signed(a) < $signed(b)) begin
               result = 16'd1;
            end else begin
               result = 16'd0;
            end
         end
         // LBI passes the immediate
         ALU_PASSB: result = b;
         default: result = a + b;
      endcase
   end

endmodule

/* rtl/branch_unit.sv */
`timescale 1ns/1ns

module branch_unit
   import cpu_isa_pkg::*;
   import cpu_ctrl_pkg::*;
(
   input  word_t    pc,
   input  word_t    rs_val,
   input  word_t    imm,
   input  br_kind_t kind,
   output logic     taken,
   output word_t    target
);

   logic rs_zero;

   assign rs_zero = (rs_val == '0);

   // Condition per control-flow kind
   always_comb begin
      case (kind)
         BR_EQZ:  taken = rs_zero;
         BR_NEZ:  taken = !rs_zero;
         BR_JUMP: taken = 1'b1;
         default: taken = 1'b0;
      endcase
   end

   // Offset counts instructions, so scale by 2
   assign target = pc + PC_STEP + (imm << 1);

endmodule

/* rtl/commit_stage.sv */
`timescale 1ns/1ns

module commit_stage
   import cpu_isa_pkg::*;
   import cpu_ctrl_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  ctrl_t    ctrl,
   input  reg_idx_t rd_sel,
   input  word_t    alu_out,
   input  word_t    mem_rdata,
   input  word_t    rt_val,
   input  logic     taken,
   input  word_t    target,
   output word_t    pc,
   output logic     rf_we,
   output word_t    wd,
   output logic     mem_we,
   output commit_t  commit,
   output logic     halted
);

   logic  valid;
   word_t pc_next;

   // Something retires every cycle out of reset until halt
   assign valid  = !rst && !halted;
   assign rf_we  = valid && ctrl.rf_we;
   assign mem_we = valid && ctrl.mem_we;

   // Write-back source
   assign wd = (ctrl.wb_sel == WB_MEM) ? mem_rdata : alu_out;

   // Branch target or sequential
   assign pc_next = taken ? target : pc + PC_STEP;

   always_ff @(posedge clk) begin
      if (rst) begin
         pc     <= '0;
         halted <= 1'b0;
      end else if (valid) begin
         // pc parks on the HALT
         if (ctrl.halt) begin
            halted <= 1'b1;
         end else begin
            pc <= pc_next;
         end
      end
   end

   // Retire record for the current pc
   always_comb begin
      commit.valid    = valid;
      commit.pc       = pc;
      commit.rf_we    = rf_we;
      commit.rd       = rd_sel;
      commit.wd       = wd;
      commit.mem_we   = mem_we;
      commit.mem_addr = alu_out;
      commit.mem_wd   = rt_val;
   end

endmodule

/* rtl/cpu_core.sv */
`timescale 1ns/1ns

module cpu_core
   import cpu_isa_pkg::*;
   import cpu_ctrl_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  imem_load_t imem_load,
   output commit_t    commit,
   output logic       halted
);

   word_t    pc;
   word_t    instr;
   reg_idx_t rs;
   reg_idx_t rt;
   reg_idx_t rd_sel;
   word_t    imm;
   ctrl_t    ctrl;
   word_t    rs_val;
   word_t    rt_val;
   word_t    alu_out;
   logic     taken;
   word_t    target;
   word_t    mem_rdata;
   logic     rf_we;
   word_t    wd;
   logic     mem_we;
   logic     imem_we;
   mem_idx_t dmem_idx;

   // Load port only writes while reset is held
   assign imem_we = rst && imem_load.we;

   // Byte address to word index
   assign dmem_idx = alu_out[MEM_AW:1];

   word_mem u_imem (
      .clk   (clk),
      .we    (imem_we),
      .waddr (imem_load.addr),
      .wdata (imem_load.data),
      .raddr (pc[MEM_AW:1]),
      .rdata (instr)
   );

   instr_decode u_dec (
      .instr  (instr),
      .rs     (rs),
      .rt     (rt),
      .rd_sel (rd_sel),
      .imm    (imm),
      .ctrl   (ctrl)
   );

   reg_file u_rf (
      .clk    (clk),
      .rst    (rst),
      .rs     (rs),
      .rt     (rt),
      .we     (rf_we),
      .wsel   (rd_sel),
      .wdata  (wd),
      .rs_val (rs_val),
      .rt_val (rt_val)
   );

   // ALU and branch unit side by side on the same operands
   alu u_alu (
      .a      (rs_val),
      .rt_val (rt_val),
      .imm    (imm),
      .ctrl   (ctrl),
      .result (alu_out)
   );

   branch_unit u_br (
      .pc     (pc),
      .rs_val (rs_val),
      .imm    (imm),
      .kind   (ctrl.br_kind),
      .taken  (taken),
      .target (target)
   );

   // Data memory, store data is Rt
   word_mem u_dmem (
      .clk   (clk),
      .we    (mem_we),
      .waddr (dmem_idx),
      .wdata (rt_val),
      .raddr (dmem_idx),
      .rdata (mem_rdata)
   );

   commit_stage u_commit (
      .clk       (clk),
      .rst       (rst),
      .ctrl      (ctrl),
      .rd_sel    (rd_sel),
      .alu_out   (alu_out),
      .mem_rdata (mem_rdata),
      .rt_val    (rt_val),
      .taken     (taken),
      .target    (target),
      .pc        (pc),
      .rf_we     (rf_we),
      .wd        (wd),
      .mem_we    (mem_we),
      .commit    (commit),
      .halted    (halted)
   );

endmodule

/* test/cpu_assert.sv */
`timescale 1ns/1ns

module cpu_assert
   import cpu_isa_pkg::*;
   import cpu_ctrl_pkg::*;
(
   input logic    clk,
   input logic    rst,
   input commit_t commit,
   input logic    halted,
   input logic    taken
);

   logic  valid;
   word_t pc;

   assign valid = commit.valid;
   assign pc    = commit.pc;

   // Nothing retires in reset or once parked on HALT
   a_idle_quiet: assert property (@(posedge clk) (rst || halted) |-> !valid)
      else $error("commit.valid high while reset or halted is high");

   // Halt is sticky until the next reset
   a_halt_sticky: assert property (@(posedge clk) ($past(halted) && !$past(rst)) |-> halted)
      else $error("halted fell without a reset");

   // Sequential flow unless the last retire redirected the pc
   a_pc_step: assert property (@(posedge clk) disable iff (rst)
      ($past(valid) && !$past(taken) && valid) |-> (pc == $past(pc) + PC_STEP))
      else $error("committed pc did not advance by 2 after a non-taken instruction");

endmodule

// Taken is internal to the core
bind cpu_core cpu_assert u_cpu_assert (
   .clk    (clk),
   .rst    (rst),
   .commit (commit),
   .halted (halted),
   .taken  (taken)
);

/* test/cpu_tb.sv */
`timescale 1ns/1ns

module cpu_tb
   import cpu_isa_pkg::*;
   import cpu_ctrl_pkg::*;
();

   localparam int RESET_CYCLES  = 10;
   localparam int HALT_HOLD     = 20;
   localparam int TIMEOUT_SLACK = 50;

   logic       clk;
   logic       rst;
   imem_load_t imem_load;
   commit_t    commit;
   logic       halted;

   // Program image and reference model state
   word_t       prog [MEM_WORDS];
   int          prog_len;
   logic [31:0] lfsr;
   word_t       m_regs [NUM_REGS];
   word_t       m_dmem [MEM_WORDS];
   word_t       m_pc;
   word_t       cur_pc;
   int          cycles = 0;
   int          limit;

   cpu_core u_dut (
      .clk       (clk),
      .rst       (rst),
      .imem_load (imem_load),
      .commit    (commit),
      .halted    (halted)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Run limit is set once the dry run knows the path length
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > limit) begin
         $display("Timeout after %0d cycles, the core never finished the program", cycles);
         $display("Test failed");
         $fatal(1);
      end
   end

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit taken
   function automatic word_t rand_bits(int n);
      word_t v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[WORD_W-2:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic reg_idx_t rand_reg();
      return reg_idx_t'(rand_bits(REG_W));
   endfunction

   // Register distinct from the two given
   function automatic reg_idx_t rand_other(reg_idx_t x, reg_idx_t y);
      reg_idx_t r;
      r = rand_reg();
      while (r == x || r == y) begin
         r = rand_reg();
      end
      return r;
   endfunction

   // Instruction encoders per format
   function automatic word_t reg_form(opcode_t op, reg_idx_t s, reg_idx_t t, reg_idx_t d);
      return {op, s, t, d, 2'b00};
   endfunction

   function automatic word_t imm5_form(opcode_t op, reg_idx_t s, reg_idx_t t, logic [4:0] k);
      return {op, s, t, k};
   endfunction

   function automatic word_t imm8_form(opcode_t op, reg_idx_t s, logic [7:0] k);
      return {op, s, k};
   endfunction

   task automatic emit(word_t w);
      prog[prog_len] = w;
      prog_len++;
   endtask

   task automatic build_program();
      reg_idx_t   ra;
      reg_idx_t   rb;
      reg_idx_t   rbase;
      reg_idx_t   rz;
      reg_idx_t   rn;
      reg_idx_t   rcnt;
      reg_idx_t   rl;
      logic [4:0] off;
      ra = rand_reg();
      rb = rand_other(ra, ra);
      // rb is negative for SLT and survives until the store
      emit(imm8_form(OP_LBI, ra, 8'(rand_bits(8))));
      emit(imm8_form(OP_LBI, rb, 8'h80 | 8'(rand_bits(7))));
      emit(reg_form(OP_ADD, ra, rb, rand_other(ra, rb)));
      emit(reg_form(OP_SUB, ra, rb, rand_other(ra, rb)));
      emit(reg_form(OP_AND, ra, rb, rand_other(ra, rb)));
      emit(reg_form(OP_XOR, ra, rb, rand_other(ra, rb)));
      emit(reg_form(OP_SLT, ra, rb, rand_other(ra, rb)));
      emit(reg_form(OP_SLT, rb, ra, rand_other(ra, rb)));
      emit(imm5_form(OP_ADDI, ra, rand_other(ra, rb), 5'(rand_bits(5))));
      // Store then load back through the same base and offset
      rbase = rand_reg();
      rl    = rand_reg();
      off   = 5'(rand_bits(5));
      emit(imm5_form(OP_ST, rbase, rb, off));
      emit(imm5_form(OP_LD, rbase, rl, off));
      emit(reg_form(OP_ADD, rl, rl, rand_reg()));
      emit(word_t'({OP_NOP, 11'd0}));
      // Branches on a zero and a nonzero register
      rz = rand_reg();
      emit(imm8_form(OP_LBI, rz, 8'd0));
      emit(imm8_form(OP_BEQZ, rz, 8'd1));
      emit(imm8_form(OP_LBI, rand_reg(), 8'h5a));
      emit(imm8_form(OP_BNEZ, rz, 8'd1));
      rn = rand_reg();
      emit(imm8_form(OP_LBI, rn, 8'h01 | 8'(rand_bits(7))));
      emit(imm8_form(OP_BEQZ, rn, 8'd1));
      emit(imm8_form(OP_BNEZ, rn, 8'd1));
      emit(imm8_form(OP_LBI, rand_reg(), 8'ha5));
      // Forward, back and forward again with the third slot never reached
      emit(word_t'({OP_J, 11'd2}));
      emit(word_t'({OP_J, 11'd2}));
      emit(imm8_form(OP_LBI, rand_reg(), 8'h3c));
      emit(word_t'({OP_J, 11'h7fd}));
      // Countdown loop of 3 to 6 passes
      rcnt = rand_reg();
      emit(imm8_form(OP_LBI, rcnt, 8'd3 + 8'(rand_bits(2))));
      emit(imm5_form(OP_ADDI, rcnt, rcnt, 5'h1f));
      emit(imm8_form(OP_BNEZ, rcnt, 8'hfe));
      emit(word_t'({OP_HALT, 11'd0}));
   endtask

   task automatic model_reset();
      for (int i = 0; i < NUM_REGS; i++) begin
         m_regs[i] = '0;
      end
      for (int i = 0; i < MEM_WORDS; i++) begin
         m_dmem[i] = '0;
      end
      m_pc = '0;
   endtask

   // Executes one instruction of the program image
   task automatic model_step(output commit_t e, output logic halt);
      word_t    ins;
      word_t    a;
      word_t    b;
      word_t    si5;
      word_t    si8;
      word_t    si11;
      word_t    addr;
      word_t    next_pc;
      reg_idx_t fs;
      reg_idx_t ft;
      reg_idx_t fd;
      ins  = prog[m_pc[MEM_AW:1]];
      fs   = ins[10:8];
      ft   = ins[7:5];
      fd   = ins[4:2];
      si5  = {{11{ins[4]}}, ins[4:0]};
      si8  = {{8{ins[7]}}, ins[7:0]};
      si11 = {{5{ins[10]}}, ins[10:0]};
      a    = m_regs[fs];
      b    = m_regs[ft];
      addr = a + si5;
      e        = '0;
      e.valid  = 1'b1;
      e.pc     = m_pc;
      halt     = 1'b0;
      next_pc  = m_pc + 16'd2;
      e.rf_we  = 1'b1;
      e.rd     = fd;
      case (opcode_t'(ins[15:11]))
         OP_ADD:  e.wd = a + b;
         OP_SUB:  e.wd = a - b;
         OP_AND:  e.wd = a & b;
         OP_XOR:  e.wd = a ^ b;
         OP_SLT:  e.wd = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
         OP_ADDI: begin
            e.rd = ft;
            e.wd = addr;
         end
         OP_LD: begin
            e.rd = ft;
            e.wd = m_dmem[addr[MEM_AW:1]];
         end
         OP_LBI: begin
            e.rd = fs;
            e.wd = si8;
         end
         OP_ST: begin
            e.rf_we    = 1'b0;
            e.mem_we   = 1'b1;
            e.mem_addr = addr;
            e.mem_wd   = b;
            m_dmem[addr[MEM_AW:1]] = b;
         end
         OP_BEQZ: begin
            e.rf_we = 1'b0;
            if (a == '0) begin
               next_pc = m_pc + 16'd2 + (si8 << 1);
            end
         end
         OP_BNEZ: begin
            e.rf_we = 1'b0;
            if (a != '0) begin
               next_pc = m_pc + 16'd2 + (si8 << 1);
            end
         end
         OP_J: begin
            e.rf_we = 1'b0;
            next_pc = m_pc + 16'd2 + (si11 << 1);
         end
         OP_HALT: begin
            e.rf_we = 1'b0;
            halt    = 1'b1;
            next_pc = m_pc;
         end
         default: e.rf_we = 1'b0;
      endcase
      if (e.rf_we) begin
         m_regs[e.rd] = e.wd;
      end
      m_pc = next_pc;
   endtask

   task automatic check_val(string name, word_t exp, word_t act);
      assert (exp == act) else begin
         $display("[FAIL] %s at pc 0x%04h: expected 0x%04h, actual 0x%04h",
                  name, cur_pc, exp, act);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   task automatic compare_commit(commit_t e);
      cur_pc = e.pc;
      check_val("commit.valid", 16'(e.valid), 16'(commit.valid));
      check_val("commit.pc", e.pc, commit.pc);
      check_val("commit.rf_we", 16'(e.rf_we), 16'(commit.rf_we));
      check_val("commit.mem_we", 16'(e.mem_we), 16'(commit.mem_we));
      // Data fields only mean something with their enable
      if (e.rf_we) begin
         check_val("commit.rd", 16'(e.rd), 16'(commit.rd));
         check_val("commit.wd", e.wd, commit.wd);
      end
      if (e.mem_we) begin
         check_val("commit.mem_addr", e.mem_addr, commit.mem_addr);
         check_val("commit.mem_wd", e.mem_wd, commit.mem_wd);
      end
   endtask

   // Memory survives reset, so a long image goes in over several 10-cycle pulses
   task automatic load_program();
      int idx;
      idx = 0;
      @(negedge clk);
      do begin
         rst = 1'b1;
         repeat (RESET_CYCLES) begin
            if (idx < prog_len) begin
               imem_load.we   = 1'b1;
               imem_load.addr = mem_idx_t'(idx);
               imem_load.data = prog[idx];
               idx++;
            end else begin
               imem_load = '0;
            end
            @(negedge clk);
         end
         imem_load = '0;
         rst       = 1'b0;
         // One free cycle between pulses
         if (idx < prog_len) begin
            @(negedge clk);
         end
      end while (idx < prog_len);
   endtask

   initial begin
      commit_t exp;
      logic    done;
      int      steps;
      int      pulses;
      rst       = 1'b1;
      imem_load = '0;
      lfsr      = 32'hcbd2_be02;
      prog_len  = 0;
      limit     = 1000000;
      for (int i = 0; i < MEM_WORDS; i++) begin
         prog[i] = '0;
      end
      build_program();
      // Dry run for the dynamic path length
      model_reset();
      steps = 0;
      done  = 1'b0;
      while (!done && steps < 8 * MEM_WORDS) begin
         model_step(exp, done);
         steps++;
      end
      pulses = (prog_len + RESET_CYCLES - 1) / RESET_CYCLES;
      limit  = pulses * (RESET_CYCLES + 1) + steps + HALT_HOLD + TIMEOUT_SLACK;
      model_reset();
      load_program();
      // Sample 1 ns after the falling edge when driven inputs have settled
      done = 1'b0;
      while (!done) begin
         #1;
         model_step(exp, done);
         compare_commit(exp);
         @(negedge clk);
      end
      // Parked on HALT and nothing more retires
      cur_pc = exp.pc;
      repeat (HALT_HOLD) begin
         #1;
         check_val("halted", 16'd1, 16'(halted));
         check_val("halt valid", 16'd0, 16'(commit.valid));
         check_val("halt rf_we", 16'd0, 16'(commit.rf_we));
         check_val("halt mem_we", 16'd0, 16'(commit.mem_we));
         check_val("halt pc", exp.pc, commit.pc);
         @(negedge clk);
      end
      $display("Test completed successfully");
      $finish;
   end

endmodule

/* compile.f */
rtl/cpu_isa_pkg.sv
rtl/cpu_ctrl_pkg.sv
rtl/word_mem.sv
rtl/reg_file.sv
rtl/instr_decode.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/commit_stage.sv
rtl/cpu_core.sv
test/cpu_assert.sv
test/cpu_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module cpu_tb -o cpu_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/cpu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
   exit 0
fi
exit 1
